// File: filelist.f
source/cpu_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_unit.sv
source/processor.sv
verification/processor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the processor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module processor_tb \
  -f filelist.f \
  -o sim_processor
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_processor)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  echo "simulation result: pass"
  exit 0
fi

echo "simulation result: fail"
exit 1

// File: source/cpu_pkg.sv
package cpu_pkg;

  // widths of the datapath and of the instruction fields
  localparam int DATA_W     = 16;
  localparam int INST_W     = 16;
  localparam int REG_ADDR_W = 3;
  localparam int PC_W       = 8;
  localparam int IMM_W      = 6;
  localparam int NUM_REGS   = 8;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [INST_W-1:0]     inst_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [PC_W-1:0]       pc_t;
  typedef logic [IMM_W-1:0]      imm_t;

  // codes not listed here decode as a no-op
  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_or   = 4'h3,
    op_slt  = 4'h4,
    op_addi = 4'h5,
    op_lw   = 4'h6,
    op_sw   = 4'h7,
    op_beq  = 4'h8,
    op_jmp  = 4'h9,
    op_halt = 4'hf
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_t;

  //////////////////////////////////////////////////
  // instruction field extraction

  function automatic opcode_t inst_opcode(input inst_t inst);
    return opcode_t'(inst[15:12]);
  endfunction

  function automatic reg_addr_t inst_rs(input inst_t inst);
    return inst[11:9];
  endfunction

  function automatic reg_addr_t inst_rt(input inst_t inst);
    return inst[8:6];
  endfunction

  function automatic reg_addr_t inst_rd(input inst_t inst);
    return inst[5:3];
  endfunction

  function automatic imm_t inst_imm(input inst_t inst);
    return inst[5:0];
  endfunction

  function automatic data_t sign_ext(input imm_t imm);
    return {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
  endfunction

endpackage

// File: source/decode_unit.sv
`timescale 1ns/100ps

module decode_unit
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  inst_t     if_inst,
  input  pc_t       if_pc,
  input  logic      if_valid,
  input  logic      branch_taken,
  input  logic      wb_reg_write,
  input  reg_addr_t wb_reg,
  input  data_t     wb_data,
  output logic      stall,
  output logic      halt_seen,
  output logic      jump_taken,
  output pc_t       jump_target,
  output logic      ex_valid,
  output opcode_t   ex_op,
  output alu_op_t   ex_alu_op,
  output reg_addr_t ex_rs,
  output reg_addr_t ex_rt,
  output reg_addr_t ex_dst,
  output data_t     ex_rs_data,
  output data_t     ex_rt_data,
  output data_t     ex_imm,
  output pc_t       ex_pc,
  output logic      ex_reg_write,
  output logic      ex_mem_read,
  output logic      ex_mem_write,
  output logic      ex_halt
);

  data_t     regs [NUM_REGS];
  opcode_t   op;
  reg_addr_t rs;
  reg_addr_t rt;
  reg_addr_t rd;
  imm_t      imm;
  alu_op_t   alu_op;
  reg_addr_t dst;
  logic      reg_write;
  logic      mem_read;
  logic      mem_write;
  logic      is_halt;
  logic      uses_rs;
  logic      uses_rt;
  data_t     rs_data;
  data_t     rt_data;
  logic      bubble;

  assign op  = inst_opcode(if_inst);
  assign rs  = inst_rs(if_inst);
  assign rt  = inst_rt(if_inst);
  assign rd  = inst_rd(if_inst);
  assign imm = inst_imm(if_inst);

  always_comb begin
    case (op)
      op_sub, op_beq: alu_op = alu_sub;
      op_and:         alu_op = alu_and;
      op_or:          alu_op = alu_or;
      op_slt:         alu_op = alu_slt;
      default:        alu_op = alu_add;
    endcase
  end

  // control decode, I form writes rt
  always_comb begin
    dst       = rt;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_halt   = 1'b0;
    uses_rs   = 1'b0;
    uses_rt   = 1'b0;
    case (op)
      op_add, op_sub, op_and, op_or, op_slt: begin
        dst       = rd;
        reg_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
      end
      op_addi: begin
        reg_write = 1'b1;
        uses_rs   = 1'b1;
      end
      op_lw: begin
        reg_write = 1'b1;
        mem_read  = 1'b1;
        uses_rs   = 1'b1;
      end
      op_sw: begin
        mem_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
      end
      op_beq: begin
        uses_rs = 1'b1;
        uses_rt = 1'b1;
      end
      op_halt: is_halt = 1'b1;
      default: begin
      end
    endcase
    // r0 is hardwired, so its writes never retire
    if (dst == '0) begin
      reg_write = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // register file, write-first on the retiring value

  always_ff @(posedge clk) begin
    if (wb_reg_write) begin
      regs[wb_reg] <= wb_data;
    end
  end

  assign rs_data = (rs == '0) ? '0 :
                   (wb_reg_write && wb_reg == rs) ? wb_data : regs[rs];
  assign rt_data = (rt == '0) ? '0 :
                   (wb_reg_write && wb_reg == rt) ? wb_data : regs[rt];

  // load in ID/EX feeding this instruction needs one bubble
  assign stall = if_valid && ex_valid && ex_mem_read &&
                 ((uses_rs && ex_rt == rs) || (uses_rt && ex_rt == rt));

  assign halt_seen   = if_valid && is_halt;
  assign jump_taken  = if_valid && op == op_jmp;
  assign jump_target = if_inst[PC_W-1:0];
  assign bubble      = !if_valid || stall || branch_taken;

  //////////////////////////////////////////////////
  // ID/EX register

  always_ff @(posedge clk) begin
    if (rst || bubble) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_halt      <= 1'b0;
    end else begin
      ex_valid     <= 1'b1;
      ex_reg_write <= reg_write;
      ex_mem_read  <= mem_read;
      ex_mem_write <= mem_write;
      ex_halt      <= is_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_op      <= op;
    ex_alu_op  <= alu_op;
    ex_rs      <= rs;
    ex_rt      <= rt;
    ex_dst     <= dst;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
    ex_imm     <= sign_ext(imm);
    ex_pc      <= if_pc;
  end

endmodule

// File: source/execute_unit.sv
`timescale 1ns/100ps

module execute_unit
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid,
  input  opcode_t   ex_op,
  input  alu_op_t   ex_alu_op,
  input  reg_addr_t ex_rs,
  input  reg_addr_t ex_rt,
  input  reg_addr_t ex_dst,
  input  data_t     ex_rs_data,
  input  data_t     ex_rt_data,
  input  data_t     ex_imm,
  input  pc_t       ex_pc,
  input  logic      ex_reg_write,
  input  logic      ex_mem_read,
  input  logic      ex_mem_write,
  input  logic      ex_halt,
  input  logic      wb_reg_write,
  input  reg_addr_t wb_reg,
  input  data_t     wb_data,
  output logic      branch_taken,
  output pc_t       branch_target,
  output logic      mem_valid,
  output data_t     mem_alu_result,
  output data_t     mem_store_data,
  output reg_addr_t mem_dst,
  output logic      mem_reg_write,
  output logic      mem_mem_read,
  output logic      mem_mem_write,
  output logic      mem_halt
);

  data_t op_a;
  data_t rt_value;
  data_t op_b;
  data_t alu_result;
  logic  use_imm;

  // youngest producer wins, r0 never forwards
  function automatic data_t select_operand(
    input reg_addr_t src,
    input data_t     reg_value,
    input logic      mem_we,
    input reg_addr_t mem_reg,
    input data_t     mem_value,
    input logic      wb_we,
    input reg_addr_t wb_addr,
    input data_t     wb_value
  );
    if (mem_we && mem_reg != '0 && mem_reg == src) begin
      return mem_value;
    end else if (wb_we && wb_addr != '0 && wb_addr == src) begin
      return wb_value;
    end
    return reg_value;
  endfunction

  assign op_a = select_operand(ex_rs, ex_rs_data, mem_reg_write, mem_dst,
                               mem_alu_result, wb_reg_write, wb_reg, wb_data);
  assign rt_value = select_operand(ex_rt, ex_rt_data, mem_reg_write, mem_dst,
                                   mem_alu_result, wb_reg_write, wb_reg, wb_data);

  // addi, lw and sw take the immediate as second operand
  assign use_imm = ex_op inside {op_addi, op_lw, op_sw};
  assign op_b    = use_imm ? ex_imm : rt_value;

  always_comb begin
    case (ex_alu_op)
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_slt: alu_result = data_t'($signed(op_a) < $signed(op_b));
      default: alu_result = op_a + op_b;
    endcase
  end

  //////////////////////////////////////////////////
  // branch resolution, target relative to the next pc

  assign branch_taken  = ex_valid && ex_op == op_beq && op_a == rt_value;
  assign branch_target = ex_pc + pc_t'(1) + ex_imm[PC_W-1:0];

  //////////////////////////////////////////////////
  // EX/MEM register

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid     <= 1'b0;
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
      mem_halt      <= 1'b0;
    end else begin
      mem_valid     <= ex_valid;
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
      mem_halt      <= ex_halt;
    end
  end

  always_ff @(posedge clk) begin
    mem_alu_result <= alu_result;
    mem_store_data <= rt_value;
    mem_dst        <= ex_dst;
  end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit
  import cpu_pkg::*;
#(
  parameter int IMEM_DEPTH = 64
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  imem_we,
  input  pc_t   imem_addr,
  input  inst_t imem_data,
  input  logic  stall,
  input  logic  halt_seen,
  input  logic  jump_taken,
  input  pc_t   jump_target,
  input  logic  branch_taken,
  input  pc_t   branch_target,
  output inst_t if_inst,
  output pc_t   if_pc,
  output logic  if_valid
);

  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  inst_t imem [IMEM_DEPTH];
  pc_t   pc;
  logic  stopped;
  logic  hold;

  // host write port on the instruction array
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[IMEM_AW-1:0]] <= imem_data;
    end
  end

  // once a halt is decoded on the right path, fetch stays frozen until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      stopped <= 1'b0;
    end else if (halt_seen && !branch_taken) begin
      stopped <= 1'b1;
    end
  end

  assign hold = stall || halt_seen || stopped;

  // next pc, older branch first
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (jump_taken) begin
      pc <= jump_target;
    end else if (!hold) begin
      pc <= pc + pc_t'(1);
    end
  end

  //////////////////////////////////////////////////
  // IF/ID register

  always_ff @(posedge clk) begin
    if (rst || branch_taken || jump_taken) begin
      if_valid <= 1'b0;
    end else if (!stall) begin
      if_valid <= !(halt_seen || stopped);
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_inst <= imem[pc[IMEM_AW-1:0]];
      if_pc   <= pc;
    end
  end

endmodule

// File: source/memory_unit.sv
`timescale 1ns/100ps

module memory_unit
  import cpu_pkg::*;
#(
  parameter int DMEM_DEPTH = 64
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      mem_valid,
  input  data_t     mem_alu_result,
  input  data_t     mem_store_data,
  input  reg_addr_t mem_dst,
  input  logic      mem_reg_write,
  input  logic      mem_mem_read,
  input  logic      mem_mem_write,
  input  logic      mem_halt,
  output logic      wb_valid,
  output logic      wb_reg_write,
  output reg_addr_t wb_reg,
  output data_t     wb_data,
  output logic      halted
);

  localparam int DMEM_AW = $clog2(DMEM_DEPTH);

  data_t              dmem [DMEM_DEPTH];
  logic [DMEM_AW-1:0] addr;
  data_t              load_data;
  data_t              wb_alu;
  logic               wb_is_load;

  // word address from the low bits of the alu result
  assign addr = mem_alu_result[DMEM_AW-1:0];

  // read is registered, lining up with MEM/WB
  always_ff @(posedge clk) begin
    if (mem_valid && mem_mem_write) begin
      dmem[addr] <= mem_store_data;
    end
    load_data <= dmem[addr];
  end

  //////////////////////////////////////////////////
  // MEM/WB register

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid     <= 1'b0;
      wb_reg_write <= 1'b0;
      halted       <= 1'b0;
    end else begin
      wb_valid     <= mem_valid && mem_reg_write;
      wb_reg_write <= mem_reg_write;
      if (mem_valid && mem_halt) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    wb_reg     <= mem_dst;
    wb_alu     <= mem_alu_result;
    wb_is_load <= mem_mem_read;
  end

  assign wb_data = wb_is_load ? load_data : wb_alu;

endmodule

// File: source/processor.sv
`timescale 1ns/100ps

module processor
  import cpu_pkg::*;
#(
  parameter int IMEM_DEPTH = 64,
  parameter int DMEM_DEPTH = 64
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      imem_we,
  input  pc_t       imem_addr,
  input  inst_t     imem_data,
  output logic      wb_valid,
  output reg_addr_t wb_reg,
  output data_t     wb_data,
  output logic      halted
);

  // IF/ID and fetch redirects
  inst_t     if_inst;
  pc_t       if_pc;
  logic      if_valid;
  logic      stall;
  logic      halt_seen;
  logic      jump_taken;
  pc_t       jump_target;
  logic      branch_taken;
  pc_t       branch_target;

  // ID/EX
  logic      ex_valid;
  opcode_t   ex_op;
  alu_op_t   ex_alu_op;
  reg_addr_t ex_rs;
  reg_addr_t ex_rt;
  reg_addr_t ex_dst;
  data_t     ex_rs_data;
  data_t     ex_rt_data;
  data_t     ex_imm;
  pc_t       ex_pc;
  logic      ex_reg_write;
  logic      ex_mem_read;
  logic      ex_mem_write;
  logic      ex_halt;

  // EX/MEM
  logic      mem_valid;
  data_t     mem_alu_result;
  data_t     mem_store_data;
  reg_addr_t mem_dst;
  logic      mem_reg_write;
  logic      mem_mem_read;
  logic      mem_mem_write;
  logic      mem_halt;

  // writeback bus, also fed back to decode and execute
  logic      wb_reg_write;

  //////////////////////////////////////////////////
  // fetch

  fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch (.*);

  //////////////////////////////////////////////////
  // decode

  decode_unit decode (.*);

  //////////////////////////////////////////////////
  // execute

  execute_unit execute (.*);

  //////////////////////////////////////////////////
  // memory and writeback

  memory_unit #(.DMEM_DEPTH(DMEM_DEPTH)) memory (.*);

endmodule

// File: verification/processor_tb.sv
`timescale 1ns/100ps

module processor_tb
  import cpu_pkg::*;
;

  localparam int NUM_PROGS    = 5;
  localparam int MAX_LEN      = 12;
  localparam int MAX_RET      = 8;
  localparam int RESET_CYCLES = 8;

  logic      clk;
  logic      rst;
  logic      imem_we;
  pc_t       imem_addr;
  inst_t     imem_data;
  logic      wb_valid;
  reg_addr_t wb_reg;
  data_t     wb_data;
  logic      halted;

  // program table with the expected retirement sequence of each row
  inst_t     prog_words [NUM_PROGS][MAX_LEN];
  int        prog_len [NUM_PROGS];
  reg_addr_t exp_reg [NUM_PROGS][MAX_RET];
  data_t     exp_val [NUM_PROGS][MAX_RET];
  int        exp_count [NUM_PROGS];

  int errors;
  int checks;
  int run_cycles;
  int cycle_limit;

  processor #(.IMEM_DEPTH(64), .DMEM_DEPTH(64)) dut (
    .clk       (clk),
    .rst       (rst),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .halted    (halted)
  );

  always #10 clk = ~clk;

  // only cycles out of reset count against the limit
  always @(posedge clk) begin
    if (!rst) begin
      run_cycles = run_cycles + 1;
      if (run_cycles >= cycle_limit) begin
        $display("timeout after %0d cycles, a program did not reach halt", run_cycles);
        $display("Checks failed");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // instruction encoding and table building

  function automatic inst_t r_word(input opcode_t op, input logic [2:0] rd,
                                   input logic [2:0] rs, input logic [2:0] rt);
    return {op, rs, rt, rd, 3'b000};
  endfunction

  function automatic inst_t i_word(input opcode_t op, input logic [2:0] rt,
                                   input logic [2:0] rs, input logic [5:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic inst_t jmp_word(input logic [11:0] addr);
    return {op_jmp, addr};
  endfunction

  task automatic put_inst(input int p, input inst_t word);
    prog_words[p][prog_len[p]] = word;
    prog_len[p] = prog_len[p] + 1;
  endtask

  task automatic expect_result(input int p, input reg_addr_t r, input data_t v);
    exp_reg[p][exp_count[p]] = r;
    exp_val[p][exp_count[p]] = v;
    exp_count[p] = exp_count[p] + 1;
  endtask

  task automatic build_table();
    int    a;
    int    b;
    int    c;
    int    d;
    data_t va;
    data_t vb;
    data_t vc;
    data_t vd;
    data_t sum;
    data_t lt;
    // random operands stay inside the signed 6-bit immediate range
    a  = int'($urandom % 64) - 32;
    b  = int'($urandom % 64) - 32;
    c  = int'($urandom % 64) - 32;
    d  = int'($urandom % 64) - 32;
    va = data_t'(a);
    vb = data_t'(b);
    vc = data_t'(c);
    vd = data_t'(d);

    // dependent alu chain where the last addi finds r7 in both EX/MEM and MEM/WB
    put_inst(0, i_word(op_addi, 3'd1, 3'd0, a[5:0]));
    put_inst(0, i_word(op_addi, 3'd2, 3'd0, b[5:0]));
    put_inst(0, r_word(op_add, 3'd3, 3'd1, 3'd2));
    put_inst(0, r_word(op_sub, 3'd4, 3'd3, 3'd1));
    put_inst(0, r_word(op_and, 3'd5, 3'd3, 3'd4));
    put_inst(0, r_word(op_or, 3'd7, 3'd5, 3'd1));
    put_inst(0, r_word(op_slt, 3'd7, 3'd1, 3'd2));
    put_inst(0, i_word(op_addi, 3'd1, 3'd7, 6'd5));
    put_inst(0, {op_halt, 12'h000});
    sum = va + vb;
    lt  = ($signed(va) < $signed(vb)) ? 16'd1 : 16'd0;
    expect_result(0, 3'd1, va);
    expect_result(0, 3'd2, vb);
    expect_result(0, 3'd3, sum);
    expect_result(0, 3'd4, sum - va);
    expect_result(0, 3'd5, sum & (sum - va));
    expect_result(0, 3'd7, (sum & (sum - va)) | va);
    expect_result(0, 3'd7, lt);
    expect_result(0, 3'd1, lt + 16'd5);

    // store, dependent loads and load-use on rs then rt
    put_inst(1, i_word(op_addi, 3'd1, 3'd0, 6'd12));
    put_inst(1, i_word(op_addi, 3'd2, 3'd0, c[5:0]));
    put_inst(1, i_word(op_sw, 3'd2, 3'd1, 6'd3));
    put_inst(1, i_word(op_lw, 3'd3, 3'd1, 6'd3));
    put_inst(1, r_word(op_add, 3'd4, 3'd3, 3'd1));
    put_inst(1, i_word(op_lw, 3'd5, 3'd1, 6'd3));
    put_inst(1, r_word(op_add, 3'd6, 3'd1, 3'd5));
    put_inst(1, i_word(op_sw, 3'd6, 3'd1, 6'd4));
    put_inst(1, i_word(op_lw, 3'd7, 3'd1, 6'd4));
    put_inst(1, {op_halt, 12'h000});
    expect_result(1, 3'd1, 16'd12);
    expect_result(1, 3'd2, vc);
    expect_result(1, 3'd3, vc);
    expect_result(1, 3'd4, vc + 16'd12);
    expect_result(1, 3'd5, vc);
    expect_result(1, 3'd6, vc + 16'd12);
    expect_result(1, 3'd7, vc + 16'd12);

    // taken beq over two, not-taken beq, jmp over one
    put_inst(2, i_word(op_addi, 3'd1, 3'd0, 6'd7));
    put_inst(2, i_word(op_addi, 3'd2, 3'd0, 6'd7));
    put_inst(2, i_word(op_beq, 3'd2, 3'd1, 6'd2));
    put_inst(2, i_word(op_addi, 3'd3, 3'd0, 6'd1));
    put_inst(2, i_word(op_addi, 3'd4, 3'd0, 6'd2));
    put_inst(2, i_word(op_beq, 3'd0, 3'd1, 6'd1));
    put_inst(2, i_word(op_addi, 3'd5, 3'd1, 6'd1));
    put_inst(2, jmp_word(12'd9));
    put_inst(2, i_word(op_addi, 3'd6, 3'd0, 6'd3));
    put_inst(2, i_word(op_addi, 3'd7, 3'd5, 6'd2));
    put_inst(2, {op_halt, 12'h000});
    expect_result(2, 3'd1, 16'd7);
    expect_result(2, 3'd2, 16'd7);
    expect_result(2, 3'd5, 16'd8);
    expect_result(2, 3'd7, 16'd10);

    // r0 stays zero and nothing retires past halt
    put_inst(3, i_word(op_addi, 3'd0, 3'd0, 6'd9));
    put_inst(3, i_word(op_addi, 3'd1, 3'd0, 6'd4));
    put_inst(3, r_word(op_add, 3'd2, 3'd0, 3'd1));
    put_inst(3, r_word(op_or, 3'd3, 3'd0, 3'd0));
    put_inst(3, {op_halt, 12'h000});
    put_inst(3, i_word(op_addi, 3'd4, 3'd0, 6'd1));
    expect_result(3, 3'd1, 16'd4);
    expect_result(3, 3'd2, 16'd4);
    expect_result(3, 3'd3, 16'd0);

    // short reload over the previous image
    put_inst(4, i_word(op_addi, 3'd1, 3'd0, d[5:0]));
    put_inst(4, r_word(op_add, 3'd2, 3'd1, 3'd1));
    put_inst(4, r_word(op_sub, 3'd3, 3'd0, 3'd1));
    put_inst(4, r_word(op_slt, 3'd4, 3'd3, 3'd2));
    put_inst(4, {op_halt, 12'h000});
    lt = ($signed(16'd0 - vd) < $signed(vd + vd)) ? 16'd1 : 16'd0;
    expect_result(4, 3'd1, vd);
    expect_result(4, 3'd2, vd + vd);
    expect_result(4, 3'd3, 16'd0 - vd);
    expect_result(4, 3'd4, lt);
  endtask

  //////////////////////////////////////////////////
  // checking and program runs

  task automatic check_equal(input string what, input data_t got, input data_t expected);
    checks = checks + 1;
    if (got !== expected) begin
      errors = errors + 1;
      $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic run_program(input int p);
    int idx;
    int hold_cycles;
    idx = 0;
    hold_cycles = (prog_len[p] + 1 > RESET_CYCLES) ? prog_len[p] + 1 : RESET_CYCLES;
    @(negedge clk);
    rst = 1'b1;
    // one program word per reset cycle
    for (int c = 0; c < hold_cycles; c++) begin
      imem_we   = (c < prog_len[p]);
      imem_addr = pc_t'(c);
      imem_data = (c < prog_len[p]) ? prog_words[p][c] : inst_t'(0);
      @(negedge clk);
      check_equal($sformatf("p%0d wb_valid in reset", p), data_t'(wb_valid), '0);
      check_equal($sformatf("p%0d halted in reset", p), data_t'(halted), '0);
    end
    imem_we = 1'b0;
    rst = 1'b0;
    @(negedge clk);
    check_equal($sformatf("p%0d wb_valid after reset", p), data_t'(wb_valid), '0);
    check_equal($sformatf("p%0d halted after reset", p), data_t'(halted), '0);
    while (halted !== 1'b1) begin
      if (wb_valid === 1'b1) begin
        if (idx < exp_count[p]) begin
          check_equal($sformatf("p%0d retirement %0d register", p, idx),
                      data_t'(wb_reg), data_t'(exp_reg[p][idx]));
          check_equal($sformatf("p%0d retirement %0d value", p, idx),
                      wb_data, exp_val[p][idx]);
        end else begin
          errors = errors + 1;
          $display("program %0d retired r%0d at %0t after its last expected result",
                   p, wb_reg, $time);
        end
        idx = idx + 1;
      end
      @(negedge clk);
    end
    check_equal($sformatf("p%0d retirements before halt", p),
                data_t'(idx), data_t'(exp_count[p]));
    check_equal($sformatf("p%0d wb_valid as halted rises", p), data_t'(wb_valid), '0);
    // the pipeline stays quiet once halted
    repeat (4) begin
      @(negedge clk);
      check_equal($sformatf("p%0d wb_valid after halt", p), data_t'(wb_valid), '0);
      check_equal($sformatf("p%0d halted held", p), data_t'(halted), 16'd1);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    imem_we     = 1'b0;
    imem_addr   = '0;
    imem_data   = '0;
    errors      = 0;
    checks      = 0;
    run_cycles  = 0;
    cycle_limit = 0;
    void'($urandom(26231));
    build_table();
    for (int p = 0; p < NUM_PROGS; p++) begin
      cycle_limit = cycle_limit + 4 * prog_len[p] + 30;
    end
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program(p);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
